//--- rvseed_pkg.sv
package rvseed_pkg;

    localparam int unsigned XLEN  = 64;
    localparam int unsigned BYTES = XLEN / 8;
    localparam int unsigned OFS_W = 3;              // byte offset within a doubleword

    typedef logic [XLEN-1:0]  xlen_t;               // data word and address
    typedef logic [4:0]       reg_addr_t;           // x0..x31
    typedef logic [BYTES-1:0] wmask_t;              // one bit per byte lane

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        ADDW,                                       // 32-bit result, sign-extended
        SUBW
    } alu_op_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

    typedef enum logic [1:0] {
        SZ_B,
        SZ_H,
        SZ_W,
        SZ_D
    } mem_size_t;

    typedef enum logic {
        ST_RUN,
        ST_HALT
    } ctrl_state_t;

    // byte mask of an access at lane 0
    function automatic wmask_t size_mask(mem_size_t size);
        case (size)
            SZ_B:    return wmask_t'(8'h01);
            SZ_H:    return wmask_t'(8'h03);
            SZ_W:    return wmask_t'(8'h0f);
            default: return wmask_t'(8'hff);
        endcase
    endfunction

    // natural alignment of an access
    function automatic logic is_aligned(mem_size_t size, logic [OFS_W-1:0] ofs);
        case (size)
            SZ_B:    return 1'b1;
            SZ_H:    return ofs[0] == 1'b0;
            SZ_W:    return ofs[1:0] == 2'b00;
            default: return ofs == '0;
        endcase
    endfunction

endpackage

//--- rvseed_alu.sv
`timescale 1ns/1ps

module rvseed_alu
    import rvseed_pkg::*;
(
    input  alu_op_t   alu_op_i,
    input  xlen_t     src1_i,
    input  xlen_t     src2_i,
    input  xlen_t     s_imm_i,       // store/load offset, already sign-extended
    input  mem_op_t   mem_op_i,
    input  mem_size_t mem_size_i,
    output xlen_t     res_o,
    output wmask_t    wmask_o,
    output xlen_t     st_data_o
);

    logic [5:0]       shamt;
    logic [31:0]      w_sum;
    logic [31:0]      w_diff;
    xlen_t            addr;
    logic [OFS_W-1:0] ofs;
    logic             lt_s;
    logic             lt_u;

    assign shamt  = src2_i[5:0];                   // RV64 uses six shift bits
    assign w_sum  = src1_i[31:0] + src2_i[31:0];
    assign w_diff = src1_i[31:0] - src2_i[31:0];
    assign addr   = src1_i + s_imm_i;              // effective address
    assign ofs    = addr[OFS_W-1:0];
    assign lt_s   = $signed(src1_i) < $signed(src2_i);
    assign lt_u   = src1_i < src2_i;

    always_comb begin
        if (mem_op_i != MEM_NONE) begin
            res_o = addr;
        end else begin
            case (alu_op_i)
                ADD:     res_o = src1_i + src2_i;
                SUB:     res_o = src1_i - src2_i;
                AND:     res_o = src1_i & src2_i;
                OR:      res_o = src1_i | src2_i;
                XOR:     res_o = src1_i ^ src2_i;
                SLL:     res_o = src1_i << shamt;
                SRL:     res_o = src1_i >> shamt;
                SRA:     res_o = xlen_t'($signed(src1_i) >>> shamt);
                SLT:     res_o = {{(XLEN-1){1'b0}}, lt_s};
                SLTU:    res_o = {{(XLEN-1){1'b0}}, lt_u};
                ADDW:    res_o = {{(XLEN-32){w_sum[31]}}, w_sum};
                SUBW:    res_o = {{(XLEN-32){w_diff[31]}}, w_diff};
                default: res_o = '0;
            endcase
        end
    end

    // store lane alignment
    always_comb begin
        if (mem_op_i == MEM_STORE) begin
            wmask_o   = size_mask(mem_size_i) << ofs;
            st_data_o = src2_i << {ofs, 3'b000};   // bytes into their lanes
        end else begin
            wmask_o   = '0;                        // nothing to write
            st_data_o = '0;
        end
    end

endmodule

//--- ex_mem_regs.sv
`timescale 1ns/1ps

module ex_mem_regs
    import rvseed_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      en_i,             // stage advance
    input  logic      valid_i,
    input  logic      reg_wen_i,
    input  reg_addr_t rd_i,
    input  xlen_t     res_i,
    input  wmask_t    wmask_i,
    input  xlen_t     st_data_i,
    input  mem_op_t   mem_op_i,
    input  mem_size_t mem_size_i,
    input  logic      mem_unsigned_i,
    input  logic      ebreak_i,
    output logic      valid_o,
    output logic      reg_wen_o,
    output reg_addr_t rd_o,
    output xlen_t     res_o,
    output wmask_t    wmask_o,
    output xlen_t     st_data_o,
    output mem_op_t   mem_op_o,
    output mem_size_t mem_size_o,
    output logic      mem_unsigned_o,
    output logic      ebreak_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o        <= 1'b0;
            reg_wen_o      <= 1'b0;
            rd_o           <= '0;
            res_o          <= '0;
            wmask_o        <= '0;
            st_data_o      <= '0;
            mem_op_o       <= MEM_NONE;
            mem_size_o     <= SZ_B;
            mem_unsigned_o <= 1'b0;
            ebreak_o       <= 1'b0;
        end else if (en_i) begin
            valid_o        <= valid_i;  // bubble when no input handshake
            reg_wen_o      <= reg_wen_i;
            rd_o           <= rd_i;
            res_o          <= res_i;
            wmask_o        <= wmask_i;
            st_data_o      <= st_data_i;
            mem_op_o       <= mem_op_i;
            mem_size_o     <= mem_size_i;
            mem_unsigned_o <= mem_unsigned_i;
            ebreak_o       <= ebreak_i;
        end
    end

    // a held op must reach the memory stage unchanged
    ap_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_o && !en_i |=> valid_o && $stable({reg_wen_o, rd_o, res_o, wmask_o, st_data_o,
                                                 mem_op_o, mem_size_o, mem_unsigned_o,
                                                 ebreak_o})
    ) else $error("EX/MEM fields changed while stalled");

endmodule

//--- rvseed_lsu.sv
`timescale 1ns/1ps

module rvseed_lsu
    import rvseed_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      adv_i,            // wb register load, qualifies RAM write
    input  logic      valid_i,
    input  logic      reg_wen_i,
    input  reg_addr_t rd_i,
    input  xlen_t     addr_i,           // ALU result, address for memory ops
    input  wmask_t    wmask_i,
    input  xlen_t     st_data_i,
    input  mem_op_t   mem_op_i,
    input  mem_size_t mem_size_i,
    input  logic      mem_unsigned_i,
    input  logic      ebreak_i,
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output xlen_t     wb_data_o,
    output logic      wb_wen_o,
    output logic      wb_ebreak_o
);

    localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    xlen_t            ram [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             st_we;
    xlen_t            rd_word;
    xlen_t            lane;
    xlen_t            ld_val;

    assign idx     = addr_i[OFS_W +: IDX_W];   // doubleword index
    assign st_we   = adv_i && valid_i && (mem_op_i == MEM_STORE);
    assign rd_word = ram[idx];
    assign lane    = rd_word >> {addr_i[OFS_W-1:0], 3'b000};

    always_ff @(posedge clk) begin
        if (st_we) begin
            for (int b = 0; b < BYTES; b++) begin
                if (wmask_i[b]) begin
                    ram[idx][8*b +: 8] <= st_data_i[8*b +: 8];
                end
            end
        end
    end

    // sign or zero expansion of the loaded lane
    always_comb begin
        case (mem_size_i)
            SZ_B: ld_val = mem_unsigned_i ? {{(XLEN-8){1'b0}}, lane[7:0]}
                                          : {{(XLEN-8){lane[7]}}, lane[7:0]};
            SZ_H: ld_val = mem_unsigned_i ? {{(XLEN-16){1'b0}}, lane[15:0]}
                                          : {{(XLEN-16){lane[15]}}, lane[15:0]};
            SZ_W: ld_val = mem_unsigned_i ? {{(XLEN-32){1'b0}}, lane[31:0]}
                                          : {{(XLEN-32){lane[31]}}, lane[31:0]};
            default: ld_val = lane;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_o  <= 1'b0;
            wb_wen_o    <= 1'b0;
            wb_ebreak_o <= 1'b0;
        end else if (adv_i) begin
            wb_valid_o  <= valid_i;
            wb_wen_o    <= valid_i && reg_wen_i && (mem_op_i != MEM_STORE) && !ebreak_i;
            wb_ebreak_o <= valid_i && ebreak_i;
        end
    end

    always_ff @(posedge clk) begin
        if (adv_i) begin
            wb_rd_o   <= rd_i;
            wb_data_o <= (mem_op_i == MEM_LOAD) ? ld_val : addr_i; // ALU result passes through
        end
    end

    ap_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_i && (mem_op_i != MEM_NONE) |-> is_aligned(mem_size_i, addr_i[OFS_W-1:0])
    ) else $error("misaligned access at %h", addr_i);

    ap_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_i && (mem_op_i != MEM_NONE) |-> addr_i[XLEN-1:OFS_W] < MEM_WORDS
    ) else $error("access beyond data memory at %h", addr_i);

endmodule

//--- rvseed_pipe_ctrl.sv
`timescale 1ns/1ps

module rvseed_pipe_ctrl
    import rvseed_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid_i,
    input  logic mem_valid_i,       // EX/MEM stage occupied
    input  logic wb_valid_i,        // wb record held
    input  logic wb_ready_i,
    input  logic wb_ebreak_i,
    output logic in_ready_o,
    output logic ex_adv_o,
    output logic wb_adv_o,
    output logic halted_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        wb_fire;

    assign wb_fire  = wb_valid_i && wb_ready_i;
    assign wb_adv_o = !wb_valid_i || wb_ready_i;      // wb slot free or draining
    assign ex_adv_o = !mem_valid_i || wb_adv_o;
    assign in_ready_o = (state_q == ST_RUN) && ex_adv_o;
    assign halted_o = (state_q == ST_HALT);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RUN: begin
                if (wb_fire && wb_ebreak_i) begin
                    state_d = ST_HALT;                // ebreak retired
                end
            end
            ST_HALT: state_d = ST_HALT;              // left only by reset
            default: state_d = ST_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    ap_no_ready_halted: assert property (
        @(posedge clk) disable iff (!rst_n)
        state_q == ST_HALT |-> !in_ready_o
    ) else $error("input ready while halted");

    // source keeps its request up until it is taken
    ap_in_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid_i && !in_ready_o && !halted_o |=> in_valid_i
    ) else $error("input valid dropped before handshake");

endmodule

//--- rvseed_exmem_top.sv
`timescale 1ns/1ps

module rvseed_exmem_top
    import rvseed_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid_i,
    output logic      in_ready_o,
    input  alu_op_t   alu_op_i,
    input  xlen_t     src1_i,
    input  xlen_t     src2_i,
    input  xlen_t     s_imm_i,
    input  reg_addr_t rd_i,
    input  logic      reg_wen_i,
    input  mem_op_t   mem_op_i,
    input  mem_size_t mem_size_i,
    input  logic      mem_unsigned_i,
    input  logic      ebreak_i,
    output logic      wb_valid_o,
    input  logic      wb_ready_i,
    output reg_addr_t wb_rd_o,
    output xlen_t     wb_data_o,
    output logic      wb_wen_o,
    output logic      halted_o
);

    xlen_t     alu_res;
    wmask_t    wmask;
    xlen_t     st_data;
    logic      ex_adv;
    logic      wb_adv;
    logic      mem_valid;
    logic      m_reg_wen;
    reg_addr_t m_rd;
    xlen_t     m_res;
    wmask_t    m_wmask;
    xlen_t     m_st_data;
    mem_op_t   m_mem_op;
    mem_size_t m_mem_size;
    logic      m_mem_unsigned;
    logic      m_ebreak;
    logic      wb_ebreak;

    rvseed_pipe_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid_i),
        .mem_valid_i (mem_valid),
        .wb_valid_i  (wb_valid_o),
        .wb_ready_i  (wb_ready_i),
        .wb_ebreak_i (wb_ebreak),
        .in_ready_o  (in_ready_o),
        .ex_adv_o    (ex_adv),
        .wb_adv_o    (wb_adv),
        .halted_o    (halted_o)
    );

    rvseed_alu u_alu (
        .alu_op_i   (alu_op_i),
        .src1_i     (src1_i),
        .src2_i     (src2_i),
        .s_imm_i    (s_imm_i),
        .mem_op_i   (mem_op_i),
        .mem_size_i (mem_size_i),
        .res_o      (alu_res),
        .wmask_o    (wmask),
        .st_data_o  (st_data)
    );

    ex_mem_regs u_ex_mem (
        .clk            (clk),
        .rst_n          (rst_n),
        .en_i           (ex_adv),
        .valid_i        (in_valid_i && in_ready_o),   // input handshake
        .reg_wen_i      (reg_wen_i),
        .rd_i           (rd_i),
        .res_i          (alu_res),
        .wmask_i        (wmask),
        .st_data_i      (st_data),
        .mem_op_i       (mem_op_i),
        .mem_size_i     (mem_size_i),
        .mem_unsigned_i (mem_unsigned_i),
        .ebreak_i       (ebreak_i),
        .valid_o        (mem_valid),
        .reg_wen_o      (m_reg_wen),
        .rd_o           (m_rd),
        .res_o          (m_res),
        .wmask_o        (m_wmask),
        .st_data_o      (m_st_data),
        .mem_op_o       (m_mem_op),
        .mem_size_o     (m_mem_size),
        .mem_unsigned_o (m_mem_unsigned),
        .ebreak_o       (m_ebreak)
    );

    rvseed_lsu #(
        .MEM_WORDS (MEM_WORDS)
    ) u_lsu (
        .clk            (clk),
        .rst_n          (rst_n),
        .adv_i          (wb_adv),
        .valid_i        (mem_valid),
        .reg_wen_i      (m_reg_wen),
        .rd_i           (m_rd),
        .addr_i         (m_res),
        .wmask_i        (m_wmask),
        .st_data_i      (m_st_data),
        .mem_op_i       (m_mem_op),
        .mem_size_i     (m_mem_size),
        .mem_unsigned_i (m_mem_unsigned),
        .ebreak_i       (m_ebreak),
        .wb_valid_o     (wb_valid_o),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o),
        .wb_wen_o       (wb_wen_o),
        .wb_ebreak_o    (wb_ebreak)
    );

endmodule

//--- tb_rvseed_exmem.sv
`timescale 1ns/1ps

module tb_rvseed_exmem
    import rvseed_pkg::*;
();

    localparam int MEM_WORDS   = 256;
    localparam int REGION      = 128;                   // bytes touched by loads and stores
    localparam int INIT_WORDS  = REGION / 8;
    localparam int N_ALU       = 150;
    localparam int N_MEM       = 120;
    localparam int N_STALL     = 150;
    localparam int N_HALT      = 4;
    localparam int TOTAL_OPS   = N_ALU + INIT_WORDS + N_MEM + N_STALL + N_HALT;
    localparam int CYCLE_LIMIT = 4 * TOTAL_OPS + 200;

    typedef logic [5+1+XLEN-1:0] wb_rec_t;              // {rd, wen, data}

    logic      clk;
    logic      rst_n;
    logic      in_valid_i;
    logic      in_ready_o;
    alu_op_t   alu_op_i;
    xlen_t     src1_i;
    xlen_t     src2_i;
    xlen_t     s_imm_i;
    reg_addr_t rd_i;
    logic      reg_wen_i;
    mem_op_t   mem_op_i;
    mem_size_t mem_size_i;
    logic      mem_unsigned_i;
    logic      ebreak_i;
    logic      wb_valid_o;
    logic      wb_ready_i;
    reg_addr_t wb_rd_o;
    xlen_t     wb_data_o;
    logic      wb_wen_o;
    logic      halted_o;

    integer    seed = 32'he0bda3b2;
    wb_rec_t   exp_q[$];
    wb_rec_t   exp_head;
    logic      take = 1'b0;                             // handshake seen, pop at next negedge
    logic      stall_en = 1'b0;
    logic [7:0] mem_bytes [MEM_WORDS*8];                // reference memory
    string     test_name = "none";
    int        errors = 0;
    int        err_start = 0;
    int        n_tests = 0;
    int        n_records = 0;
    int        cycles;

    rvseed_exmem_top #(
        .MEM_WORDS (MEM_WORDS)
    ) rvseed_exmem_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .alu_op_i       (alu_op_i),
        .src1_i         (src1_i),
        .src2_i         (src2_i),
        .s_imm_i        (s_imm_i),
        .rd_i           (rd_i),
        .reg_wen_i      (reg_wen_i),
        .mem_op_i       (mem_op_i),
        .mem_size_i     (mem_size_i),
        .mem_unsigned_i (mem_unsigned_i),
        .ebreak_i       (ebreak_i),
        .wb_valid_o     (wb_valid_o),
        .wb_ready_i     (wb_ready_i),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o),
        .wb_wen_o       (wb_wen_o),
        .halted_o       (halted_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // reference ALU on signed integer types
    function automatic xlen_t alu_model(alu_op_t op, xlen_t a, xlen_t b);
        longint sa;
        longint sb;
        int     ws;
        int     wd;
        sa = a;
        sb = b;
        ws = int'(a[31:0] + b[31:0]);
        wd = int'(a[31:0] - b[31:0]);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[5:0];
            SRL:     return a >> b[5:0];
            SRA:     return xlen_t'(sa >>> b[5:0]);
            SLT:     return (sa < sb) ? 64'd1 : 64'd0;
            SLTU:    return (a < b) ? 64'd1 : 64'd0;
            ADDW:    return xlen_t'(longint'(ws));
            default: return xlen_t'(longint'(wd));
        endcase
    endfunction

    task automatic check_bit(input string what, input logic exp, input logic act);
        assert (act === exp) else begin
            errors++;
            $display("Error in test %s: %s expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    // hold one op on the input port until it is taken
    task automatic issue(input alu_op_t op, input xlen_t a, input xlen_t b, input xlen_t imm,
                         input reg_addr_t rd, input logic wen, input mem_op_t mop,
                         input mem_size_t sz, input logic uns, input logic brk,
                         input wb_rec_t exp);
        logic taken;
        alu_op_i       = op;
        src1_i         = a;
        src2_i         = b;
        s_imm_i        = imm;
        rd_i           = rd;
        reg_wen_i      = wen;
        mem_op_i       = mop;
        mem_size_i     = sz;
        mem_unsigned_i = uns;
        ebreak_i       = brk;
        in_valid_i     = 1'b1;
        taken          = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready_o;                         // stable mid-cycle
            @(posedge clk);
            #1;
        end
        exp_q.push_back(exp);
        in_valid_i = 1'b0;
    endtask

    task automatic random_alu(input logic brk);
        alu_op_t     op;
        xlen_t       a;
        xlen_t       b;
        logic [31:0] r;
        r  = rand32();
        op = alu_op_t'(4'(r[7:0] % 12));
        a  = {rand32(), rand32()};
        b  = r[15] ? a : {rand32(), rand32()};          // equal operands now and then
        issue(op, a, b, {rand32(), rand32()}, r[13:9], r[14], MEM_NONE, SZ_B, 1'b0, brk,
              {r[13:9], r[14] && !brk, alu_model(op, a, b)});
    endtask

    task automatic memory_access(input mem_op_t kind);
        mem_size_t   sz;
        int          nbytes;
        int          simm;
        xlen_t       addr;
        xlen_t       imm;
        xlen_t       data;
        xlen_t       ld;
        logic [31:0] r;
        r      = rand32();
        sz     = mem_size_t'(r[1:0]);
        nbytes = 1 << r[1:0];
        addr   = xlen_t'((rand32() % REGION) & ~(nbytes - 1));  // natural alignment
        simm   = $signed(r[10:4]);
        imm    = xlen_t'(longint'(simm));
        data   = {rand32(), rand32()};
        if (kind == MEM_STORE) begin
            for (int i = 0; i < nbytes; i++) begin
                mem_bytes[addr + i] = data[8*i +: 8];
            end
            issue(ADD, addr - imm, data, imm, r[15:11], r[3], kind, sz, r[2], 1'b0,
                  {r[15:11], 1'b0, addr});
        end else begin
            ld = '0;
            for (int i = 0; i < 8; i++) begin
                if (i < nbytes) begin
                    ld[8*i +: 8] = mem_bytes[addr + i];
                end else if (!r[2] && ld[8*nbytes-1]) begin
                    ld[8*i +: 8] = 8'hff;               // sign fill
                end
            end
            issue(ADD, addr - imm, data, imm, r[15:11], r[3], kind, sz, r[2], 1'b0,
                  {r[15:11], r[3], ld});
        end
    endtask

    task automatic drain();
        in_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test();
        drain();
        n_tests++;
        $display("test %s finished with %0d errors", test_name, errors - err_start);
    endtask

    // back-pressure on the wb port
    always @(posedge clk) begin
        logic [31:0] r;
        logic        rdy;
        r   = rand32();
        rdy = stall_en ? r[0] : 1'b1;
        #1;
        wb_ready_i = rdy;
    end

    always @(negedge clk) begin
        if (take && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            n_records++;
        end
        exp_head = (exp_q.size() > 0) ? exp_q[0] : 'x;  // empty queue fails any compare
        take = rst_n && wb_valid_o && wb_ready_i;
    end

    ap_wb_record: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_valid_o && wb_ready_i |-> {wb_rd_o, wb_wen_o, wb_data_o} == exp_head
    ) else begin
        errors++;
        $display("Error in test %s: expected rd %0d wen %b data %h, actual rd %0d wen %b data %h",
                 test_name, exp_head[69:65], exp_head[64], exp_head[63:0],
                 $sampled(wb_rd_o), $sampled(wb_wen_o), $sampled(wb_data_o));
    end

    ap_wb_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable({wb_rd_o, wb_wen_o, wb_data_o})
    ) else begin
        errors++;
        $display("wb record changed while stalled in test %s", test_name);
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles in test %s with %0d records outstanding",
                 cycles, test_name, exp_q.size());
        $display("Something failed");
        $finish;
    end

    initial begin
        xlen_t       data;
        logic [31:0] r;
        rst_n          = 1'b0;
        in_valid_i     = 1'b0;
        alu_op_i       = ADD;
        src1_i         = '0;
        src2_i         = '0;
        s_imm_i        = '0;
        rd_i           = '0;
        reg_wen_i      = 1'b0;
        mem_op_i       = MEM_NONE;
        mem_size_i     = SZ_B;
        mem_unsigned_i = 1'b0;
        ebreak_i       = 1'b0;
        wb_ready_i     = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test("reset");
        @(negedge clk);
        check_bit("wb_valid_o", 1'b0, wb_valid_o);
        check_bit("in_ready_o", 1'b1, in_ready_o);
        check_bit("halted_o", 1'b0, halted_o);
        end_test();

        start_test("alu");
        for (int i = 0; i < N_ALU; i++) begin
            random_alu(1'b0);
        end
        end_test();

        start_test("mem");
        for (int w = 0; w < INIT_WORDS; w++) begin          // RAM starts unknown
            data = {rand32(), rand32()};
            for (int i = 0; i < 8; i++) begin
                mem_bytes[8*w + i] = data[8*i +: 8];
            end
            issue(ADD, xlen_t'(8*w), data, '0, 5'd0, 1'b0, MEM_STORE, SZ_D, 1'b0, 1'b0,
                  {5'd0, 1'b0, xlen_t'(8*w)});
        end
        for (int i = 0; i < N_MEM; i++) begin
            r = rand32();
            memory_access(r[0] ? MEM_LOAD : MEM_STORE);
        end
        end_test();

        start_test("stall");
        stall_en = 1'b1;
        for (int i = 0; i < N_STALL; i++) begin
            r = rand32();
            if (r[1:0] == 2'd0) begin
                memory_access(MEM_STORE);
            end else if (r[1:0] == 2'd1) begin
                memory_access(MEM_LOAD);
            end else begin
                random_alu(1'b0);
            end
        end
        end_test();

        start_test("halt");
        for (int i = 0; i < N_HALT - 1; i++) begin
            random_alu(1'b0);
        end
        random_alu(1'b1);
        while (!halted_o) begin
            @(negedge clk);
        end
        @(negedge clk);
        check_bit("earlier records done", 1'b1, exp_q.size() == 0);
        @(posedge clk);
        #1;
        in_valid_i = 1'b1;                              // must not be taken
        repeat (8) begin
            @(negedge clk);
            check_bit("in_ready_o", 1'b0, in_ready_o);
            check_bit("halted_o", 1'b1, halted_o);
        end
        @(posedge clk);
        #1;
        in_valid_i = 1'b0;
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("in_ready_o after reset", 1'b1, in_ready_o);
        check_bit("halted_o after reset", 1'b0, halted_o);
        check_bit("wb_valid_o after reset", 1'b0, wb_valid_o);
        end_test();

        $display("%0d tests, %0d records checked, %0d errors", n_tests, n_records, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- rvseed_exmem.f
rvseed_pkg.sv
rvseed_alu.sv
ex_mem_regs.sv
rvseed_lsu.sv
rvseed_pipe_ctrl.sv
rvseed_exmem_top.sv
tb_rvseed_exmem.sv
